// File: verif/pfpu_cases.txt
1 12345678 11111111 23456789 0
2 00000005 00000007 fffffffe 0
1 ffffffff 00000002 00000001 0
3 00003039 00000064 0012d644 0
3 ffffffff ffffffff 00000001 0
4 f0f0a5a5 0ff0ffff 00f0a5a5 0
5 f000000f 0a0b0c00 fa0b0c0f 0
6 deadbeef ffff0000 2152beef 0
7 00000001 00000024 00000010 0
8 80000000 0000001f 00000001 0
7 12345678 00000008 34567800 0
9 aaaaaaaa 55555555 aaaaaaaa 1
9 aaaaaaaa 55555555 55555555 2
8 deadbeef 00000004 0deadbee 3

// File: list.f
hdl/pfpu_pkg.sv
hdl/pfpu_csr_pkg.sv
hdl/pfpu_tpram.sv
hdl/pfpu_regf.sv
hdl/pfpu_arith.sv
hdl/pfpu_logic.sv
hdl/pfpu_alu.sv
hdl/pfpu_seq.sv
hdl/pfpu_csr_axil.sv
hdl/pfpu_top.sv
verif/pfpu_tb.sv

// File: run.sh
#!/bin/sh
# build the vertex unit testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module pfpu_tb -f list.f -o pfpu_sim
status=0
./obj_dir/pfpu_sim > sim.log 2>&1 || status=$?
cat sim.log
if grep -qx "Test OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, exit status $status"
	exit 1
fi

// File: verif/pfpu_tb.sv
// ----------------------------------------------------------------------
// vertex unit testbench.
// drives the AXI4-Lite port, runs the programs in the cases file
// and checks every read against the expected words.
// ----------------------------------------------------------------------
module pfpu_tb;
	import pfpu_pkg::*;
	import pfpu_csr_pkg::*;

	localparam int max_cases = 20; // the cases file may hold up to this many lines.
	localparam int case_cycles = 150; // worst cost of one case including its status polls.
	localparam int cycle_limit = max_cases * case_cycles + 1000; // margin for the fixed tests.

	logic sys_clk;
	logic rst;
	logic [axil_aw-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [data_w-1:0] wdata;
	logic [data_w/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [axil_aw-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [data_w-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	int seed = 32'h62e1_eebe; // fixed seed so every run draws the same registers.
	int cycle_cnt = 0;
	int n_cases;
	logic [3:0] c_op [max_cases];
	logic [data_w-1:0] c_x [max_cases];
	logic [data_w-1:0] c_y [max_cases];
	logic [data_w-1:0] c_exp [max_cases];
	logic [1:0] c_flags [max_cases];

	pfpu_top i_pfpu_top (.*);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk; // period of 20.
	end

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		assert (cycle_cnt < cycle_limit) else begin
			$display("timeout: the test did not finish within %0d clock cycles", cycle_limit);
			stop_on_error();
		end
	end

	task automatic stop_on_error();
		$display("Test FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic expect_eq(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	// one write: AW and W together, then wait for B. bready stays high.
	task automatic write_word(input logic [axil_aw-1:0] addr, input logic [31:0] data);
		@(posedge sys_clk);
		awaddr <= addr;
		wdata <= data;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		do @(negedge sys_clk); while (!awready); // ready is a single-cycle pulse.
		expect_eq("wready", 32'(wready), 32'h1); // W is taken in the same cycle as AW.
		@(posedge sys_clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		do @(negedge sys_clk); while (!bvalid);
		expect_eq("bresp", 32'(bresp), 32'(resp_okay)); // B completes on the next edge.
	endtask

	// one read. rready stays high so the data is taken at the next edge.
	task automatic read_word(input logic [axil_aw-1:0] addr, output logic [31:0] data);
		@(posedge sys_clk);
		araddr <= addr;
		arvalid <= 1'b1;
		do @(negedge sys_clk); while (!arready);
		@(posedge sys_clk);
		arvalid <= 1'b0;
		do @(negedge sys_clk); while (!rvalid);
		data = rdata;
		expect_eq("rresp", 32'(rresp), 32'(resp_okay));
	endtask

	task automatic wait_idle();
		logic [31:0] st;
		st = 32'h1 << st_busy; // read at least once.
		while (st[st_busy]) begin
			read_word(addr_status, st);
		end
	endtask

	// the windows are only touched once a poll shows the unit idle.
	task automatic write_reg(input int n, input logic [31:0] data);
		wait_idle();
		write_word(reg_base + 12'(n * 4), data);
	endtask

	task automatic read_reg(input int n, output logic [31:0] data);
		wait_idle();
		read_word(reg_base + 12'(n * 4), data);
	endtask

	task automatic write_code(input int n, input logic [31:0] data);
		wait_idle();
		write_word(code_base + 12'(n * 4), data);
	endtask

	function automatic int rand_reg();
		return 3 + int'($unsigned($random(seed)) % 32'd125); // registers 3 to 127.
	endfunction

	function automatic logic [31:0] make_insn(input logic [3:0] op, input int rd,
			input int ra, input int rb);
		logic [31:0] w;
		w = '0;
		w[insn_op_lo +: insn_op_w] = op;
		w[insn_dest_lo +: reg_aw] = 7'(rd);
		w[insn_a_lo +: reg_aw] = 7'(ra);
		w[insn_b_lo +: reg_aw] = 7'(rb);
		return w;
	endfunction

	task automatic run_program(input int len);
		logic [31:0] st;
		write_word(addr_len, 32'(len));
		write_word(addr_ctrl, 32'h1 << ctrl_start);
		st = '0;
		while (!st[st_done]) begin
			read_word(addr_status, st); // start cleared done, so this waits for the run.
		end
		expect_eq("status busy", 32'(st[st_busy]), 32'h0);
	endtask

	// columns are opcode, x, y, expected result and flags, all in hex.
	task automatic load_cases();
		int fd;
		int n;
		logic [31:0] op, x, y, e, f;
		fd = $fopen("verif/pfpu_cases.txt", "r");
		assert (fd != 0) else begin
			$display("cannot open the cases file verif/pfpu_cases.txt");
			stop_on_error();
		end
		n_cases = 0;
		n = $fscanf(fd, "%h %h %h %h %h\n", op, x, y, e, f);
		while (n == 5 && n_cases < max_cases) begin
			c_op[n_cases] = op[3:0];
			c_x[n_cases] = x;
			c_y[n_cases] = y;
			c_exp[n_cases] = e;
			c_flags[n_cases] = f[1:0];
			n_cases++;
			n = $fscanf(fd, "%h %h %h %h %h\n", op, x, y, e, f);
		end
		$fclose(fd);
		assert (n_cases >= 2) else begin
			$display("the cases file holds fewer than two usable lines");
			stop_on_error();
		end
	endtask

	// x in base, y in base+1, result lands in base+2.
	task automatic run_case(input int k);
		int base;
		logic [31:0] got;
		base = 3 + int'($unsigned($random(seed)) % 32'd120);
		write_reg(base, c_x[k]);
		write_reg(base + 1, c_y[k]);
		write_reg(base + 2, ~c_exp[k]); // a stale match cannot pass.
		write_reg(int'(reg_flags), 32'(c_flags[k]));
		write_code(0, make_insn(c_op[k], base + 2, base, base + 1));
		write_code(1, make_insn(4'(op_nop), 0, 0, 0));
		run_program(2);
		read_reg(base + 2, got);
		expect_eq($sformatf("case %0d result in reg %0d", k, base + 2), got, c_exp[k]);
	endtask

	// the first two cases back to back, so two results are in flight at once.
	task automatic run_pair();
		int base;
		logic [31:0] got;
		base = 3 + int'($unsigned($random(seed)) % 32'd115);
		write_reg(base, c_x[0]);
		write_reg(base + 1, c_y[0]);
		write_reg(base + 2, c_x[1]);
		write_reg(base + 3, c_y[1]);
		write_reg(base + 4, ~c_exp[0]);
		write_reg(base + 5, ~c_exp[1]);
		write_reg(int'(reg_flags), 32'(c_flags[0])); // both cases share one flags value.
		write_code(0, make_insn(c_op[0], base + 4, base, base + 1));
		write_code(1, make_insn(c_op[1], base + 5, base + 2, base + 3));
		write_code(2, make_insn(4'(op_nop), 0, 0, 0));
		run_program(3);
		read_reg(base + 4, got);
		expect_eq($sformatf("first result in reg %0d", base + 4), got, c_exp[0]);
		read_reg(base + 5, got);
		expect_eq($sformatf("second result in reg %0d", base + 5), got, c_exp[1]);
	endtask

	initial begin
		logic [31:0] got;
		logic [31:0] wv;
		int n;
		rst <= 1'b1;
		awaddr <= '0;
		awvalid <= 1'b0;
		wdata <= '0;
		wstrb <= '1;
		wvalid <= 1'b0;
		bready <= 1'b1;
		araddr <= '0;
		arvalid <= 1'b0;
		rready <= 1'b1;
		load_cases();
		repeat (8) @(posedge sys_clk);
		rst <= 1'b0;

		read_word(addr_status, got); // idle, not done and no stray after reset.
		expect_eq("status after reset", got, 32'h0);

		for (int k = 0; k < 8; k++) begin
			n = rand_reg();
			wv = $random(seed);
			write_reg(n, wv);
			read_reg(n, got);
			expect_eq($sformatf("reg %0d", n), got, wv);
		end

		write_word(addr_r0, 32'h0bad_f00d);
		write_word(addr_r1, 32'h1357_9bdf);
		read_reg(0, got);
		expect_eq("reg 0", got, 32'h0bad_f00d);
		read_reg(1, got);
		expect_eq("reg 1", got, 32'h1357_9bdf);
		write_reg(int'(reg_flags), 32'hffff_fffe);
		read_reg(int'(reg_flags), got);
		expect_eq("reg 2", got, 32'h0000_0002); // only two flag bits exist.
		read_word(addr_status, got);
		expect_eq("status stray", 32'(got[st_stray]), 32'h0);

		write_reg(0, 32'h5a5a_5a5a); // R0 is an input, so this write is stray.
		read_word(addr_status, got);
		expect_eq("status stray", 32'(got[st_stray]), 32'h1);
		read_reg(0, got);
		expect_eq("reg 0", got, 32'h0bad_f00d);
		write_word(addr_ctrl, 32'h1 << ctrl_clr);
		read_word(addr_status, got);
		expect_eq("status stray", 32'(got[st_stray]), 32'h0);

		for (int k = 0; k < n_cases; k++) begin
			run_case(k);
		end
		run_pair();

		read_word(addr_status, got);
		expect_eq("status stray", 32'(got[st_stray]), 32'h0);
		expect_eq("status done", 32'(got[st_done]), 32'h1);
		$display("Test OK");
		$finish;
	end
endmodule

// File: hdl/pfpu_top.sv
// ----------------------------------------------------------------------
// vertex unit top level.
// host port, sequencer, register file and ALU.
// ----------------------------------------------------------------------
module pfpu_top (
	input  logic sys_clk,
	input  logic rst,
	input  logic [pfpu_csr_pkg::axil_aw-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [pfpu_pkg::data_w-1:0] wdata,
	input  logic [pfpu_pkg::data_w/8-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [pfpu_csr_pkg::axil_aw-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [pfpu_pkg::data_w-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready
);
	import pfpu_pkg::*;

	logic c_en, c_w_en, code_we, start, busy, done, err_stray;
	logic [reg_aw-1:0] c_addr;
	logic [data_w-1:0] c_di, c_do, code_di, r0_val, r1_val;
	logic [code_aw-1:0] code_addr;
	logic [code_aw:0] prog_len;
	logic [reg_aw-1:0] a_addr, b_addr, dest, w_addr;
	pfpu_op_e op;
	logic issue, w_en;
	logic [data_w-1:0] a, b, r;
	logic [1:0] flags;

	pfpu_csr_axil i_csr_axil (.*);

	pfpu_seq i_seq (.*);

	pfpu_regf i_regf (
		.r0(r0_val), // host inputs appear as R0 and R1.
		.r1(r1_val),
		.*
	);

	pfpu_alu i_alu (.*);
endmodule

// File: hdl/pfpu_csr_axil.sv
// ----------------------------------------------------------------------
// host port.
// AXI4-Lite slave for control, status, the input values and the
// register and code windows.
// ----------------------------------------------------------------------
module pfpu_csr_axil (
	input  logic sys_clk,
	input  logic rst,
	input  logic [pfpu_csr_pkg::axil_aw-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [pfpu_pkg::data_w-1:0] wdata,
	input  logic [pfpu_pkg::data_w/8-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [pfpu_csr_pkg::axil_aw-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [pfpu_pkg::data_w-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	output logic c_en,
	output logic [pfpu_pkg::reg_aw-1:0] c_addr,
	output logic c_w_en,
	output logic [pfpu_pkg::data_w-1:0] c_di,
	input  logic [pfpu_pkg::data_w-1:0] c_do,
	output logic code_we,
	output logic [pfpu_pkg::code_aw-1:0] code_addr,
	output logic [pfpu_pkg::data_w-1:0] code_di,
	output logic start,
	output logic [pfpu_pkg::code_aw:0] prog_len,
	output logic [pfpu_pkg::data_w-1:0] r0_val,
	output logic [pfpu_pkg::data_w-1:0] r1_val,
	input  logic busy,
	input  logic done,
	input  logic err_stray
);
	import pfpu_pkg::*;
	import pfpu_csr_pkg::*;

	logic aw_hs, ar_hs, wr_go, rd_go, ctrl_wr;
	logic aw_reg_win, aw_code_win, ar_reg_win, ar_code_win;
	logic rd_pend; // register read waits one cycle for the RAM.
	logic stray;
	logic [data_w-1:0] rd_mux;

	function automatic logic in_win(input logic [axil_aw-1:0] addr,
			input logic [axil_aw-1:0] base);
		return addr[axil_aw-1:win_lsb] == base[axil_aw-1:win_lsb];
	endfunction

	assign aw_reg_win = in_win(awaddr, reg_base);
	assign aw_code_win = in_win(awaddr, code_base);
	assign ar_reg_win = in_win(araddr, reg_base);
	assign ar_code_win = in_win(araddr, code_base);

	// one transfer at a time; windows wait while a run owns the register file.
	assign wr_go = awvalid & wvalid & ~awready & ~bvalid & ~arready & ~rd_pend & ~rvalid
		& ~(busy & (aw_reg_win | aw_code_win));
	assign rd_go = arvalid & ~arready & ~rd_pend & ~rvalid & ~awready & ~bvalid & ~wr_go
		& ~(busy & (ar_reg_win | ar_code_win));
	assign aw_hs = awready & awvalid & wvalid;
	assign ar_hs = arready & arvalid;
	assign ctrl_wr = aw_hs & (awaddr == addr_ctrl);

	assign c_en = (aw_hs & aw_reg_win) | (ar_hs & ar_reg_win);
	assign c_w_en = aw_hs & aw_reg_win;
	assign c_addr = aw_hs ? awaddr[2 +: reg_aw] : araddr[2 +: reg_aw];
	assign c_di = wdata; // wstrb is not looked at, writes are whole words.
	assign code_we = aw_hs & aw_code_win;
	assign code_addr = awaddr[2 +: code_aw];
	assign code_di = wdata;
	assign start = ctrl_wr & wdata[ctrl_start];
	assign bresp = resp_okay;
	assign rresp = resp_okay;

	always_comb begin
		rd_mux = '0; // unmapped and write-only addresses read zero.
		case (araddr)
			addr_status: begin
				rd_mux[st_busy] = busy;
				rd_mux[st_done] = done;
				rd_mux[st_stray] = stray;
			end
			addr_r0: rd_mux = r0_val;
			addr_r1: rd_mux = r1_val;
			addr_len: rd_mux[code_aw:0] = prog_len;
			default: ;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			r0_val <= '0;
			r1_val <= '0;
			prog_len <= '0;
			stray <= 1'b0;
		end else begin
			awready <= wr_go; // a one-cycle ready pulse per accepted write.
			wready <= wr_go;
			if (aw_hs) begin
				bvalid <= 1'b1;
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
			if (aw_hs) begin
				case (awaddr)
					addr_r0: r0_val <= wdata;
					addr_r1: r1_val <= wdata;
					addr_len: prog_len <= wdata[code_aw:0];
					default: ;
				endcase
			end
			if (err_stray) begin
				stray <= 1'b1; // a new stray write wins over a clear.
			end else if (ctrl_wr && wdata[ctrl_clr]) begin
				stray <= 1'b0;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rd_pend <= 1'b0;
		end else begin
			arready <= rd_go;
			rd_pend <= ar_hs & ar_reg_win;
			if ((ar_hs && !ar_reg_win) || rd_pend) begin
				rvalid <= 1'b1;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (ar_hs) begin
			rdata <= rd_mux;
		end else if (rd_pend) begin
			rdata <= c_do; // register data is ready one cycle after the address.
		end
	end
endmodule

// File: hdl/pfpu_seq.sv
// ----------------------------------------------------------------------
// instruction sequencer.
// code memory, program counter and the run and drain FSM.
// ----------------------------------------------------------------------
module pfpu_seq (
	input  logic sys_clk,
	input  logic rst,
	input  logic code_we,
	input  logic [pfpu_pkg::code_aw-1:0] code_addr,
	input  logic [pfpu_pkg::data_w-1:0] code_di,
	input  logic start,
	input  logic [pfpu_pkg::code_aw:0] prog_len,
	output logic [pfpu_pkg::reg_aw-1:0] a_addr,
	output logic [pfpu_pkg::reg_aw-1:0] b_addr,
	output pfpu_pkg::pfpu_op_e op,
	output logic [pfpu_pkg::reg_aw-1:0] dest,
	output logic issue,
	output logic busy,
	output logic done
);
	import pfpu_pkg::*;

	logic [data_w-1:0] code_mem [2**code_aw];
	logic [data_w-1:0] insn;
	logic [code_aw-1:0] pc;
	logic drain_cnt; // counts the two cycles the last results need to land.
	seq_state_e state;

	always_ff @(posedge sys_clk) begin
		if (code_we) begin
			code_mem[code_addr] <= code_di;
		end
	end

	assign insn = code_mem[pc]; // combinational fetch, no fetch stage.
	assign op = pfpu_op_e'(insn[insn_op_lo +: insn_op_w]);
	assign dest = insn[insn_dest_lo +: reg_aw];
	assign a_addr = insn[insn_a_lo +: reg_aw];
	assign b_addr = insn[insn_b_lo +: reg_aw];
	assign issue = (state == seq_run);
	assign busy = (state != seq_idle);

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			state <= seq_idle;
			pc <= '0;
			drain_cnt <= 1'b0;
			done <= 1'b0;
		end else begin
			case (state)
				seq_idle: begin
					drain_cnt <= 1'b0;
					if (start) begin
						pc <= '0;
						done <= 1'b0;
						state <= (prog_len == '0) ? seq_drain : seq_run; // empty run only drains.
					end
				end
				seq_run: begin
					pc <= pc + 1'b1;
					if ({1'b0, pc} == prog_len - 1'b1) begin
						state <= seq_drain;
					end
				end
				seq_drain: begin
					drain_cnt <= 1'b1;
					if (drain_cnt) begin
						state <= seq_idle;
						done <= 1'b1; // stays set until the next start.
					end
				end
				default: state <= seq_idle;
			endcase
		end
	end
endmodule

// File: hdl/pfpu_alu.sv
// ----------------------------------------------------------------------
// ALU combiner.
// runs both units side by side and picks the write-back result.
// ----------------------------------------------------------------------
module pfpu_alu (
	input  logic sys_clk,
	input  logic rst,
	input  logic issue,
	input  pfpu_pkg::pfpu_op_e op,
	input  logic [pfpu_pkg::reg_aw-1:0] dest,
	input  logic [pfpu_pkg::data_w-1:0] a,
	input  logic [pfpu_pkg::data_w-1:0] b,
	input  logic [1:0] flags,
	output logic [pfpu_pkg::data_w-1:0] r,
	output logic [pfpu_pkg::reg_aw-1:0] w_addr,
	output logic w_en
);
	import pfpu_pkg::*;

	pfpu_op_e op_d1, op_d2; // d1 lines up with the operands, d2 with the results.
	logic [reg_aw-1:0] dest_d1, dest_d2;
	logic issue_d1, issue_d2;
	logic [data_w-1:0] arith_res, logic_res;
	logic use_arith;

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			issue_d1 <= 1'b0;
			issue_d2 <= 1'b0;
		end else begin
			issue_d1 <= issue;
			issue_d2 <= issue_d1;
		end
	end

	always_ff @(posedge sys_clk) begin
		op_d1 <= op;
		op_d2 <= op_d1;
		dest_d1 <= dest;
		dest_d2 <= dest_d1;
	end

	pfpu_arith i_arith (
		.sys_clk(sys_clk),
		.op(op_d1),
		.a(a),
		.b(b),
		.res(arith_res)
	);

	pfpu_logic i_logic (
		.sys_clk(sys_clk),
		.op(op_d1),
		.a(a),
		.b(b),
		.flags(flags),
		.res(logic_res)
	);

	assign use_arith = op_d2 inside {op_add, op_sub, op_mul};
	assign r = use_arith ? arith_res : logic_res;
	assign w_addr = dest_d2;
	assign w_en = issue_d2 & (op_d2 != op_nop); // a nop leaves the registers alone.
endmodule

// File: hdl/pfpu_logic.sv
// ----------------------------------------------------------------------
// logic and select unit.
// registered bitwise ops, shifts and the flag-driven select.
// ----------------------------------------------------------------------
module pfpu_logic (
	input  logic sys_clk,
	input  pfpu_pkg::pfpu_op_e op,
	input  logic [pfpu_pkg::data_w-1:0] a,
	input  logic [pfpu_pkg::data_w-1:0] b,
	input  logic [1:0] flags,
	output logic [pfpu_pkg::data_w-1:0] res
);
	import pfpu_pkg::*;

	always_ff @(posedge sys_clk) begin
		case (op)
			op_or: res <= a | b;
			op_xor: res <= a ^ b;
			op_shl: res <= a << b[4:0]; // only the low five bits of b count.
			op_shr: res <= a >> b[4:0]; // logical shift, zeros come in.
			op_sel: res <= flags[0] ? a : b;
			default: res <= a & b;
		endcase
	end
endmodule

// File: hdl/pfpu_arith.sv
// ----------------------------------------------------------------------
// arithmetic unit.
// registered add, subtract and low-half multiply.
// ----------------------------------------------------------------------
module pfpu_arith (
	input  logic sys_clk,
	input  pfpu_pkg::pfpu_op_e op,
	input  logic [pfpu_pkg::data_w-1:0] a,
	input  logic [pfpu_pkg::data_w-1:0] b,
	output logic [pfpu_pkg::data_w-1:0] res
);
	import pfpu_pkg::*;

	always_ff @(posedge sys_clk) begin
		case (op)
			op_sub: begin
				res <= a - b;
			end
			op_mul: begin
				res <= a * b; // the upper half of the product is dropped.
			end
			default: begin
				res <= a + b; // the combiner ignores this for non-arithmetic ops.
			end
		endcase
	end
endmodule

// File: hdl/pfpu_regf.sv
// ----------------------------------------------------------------------
// register file.
// RAM with R0, R1 and flag overlays, host and ALU port sharing,
// and detection of writes to R0.
// ----------------------------------------------------------------------
module pfpu_regf (
	input  logic sys_clk,
	input  logic rst,
	output logic [1:0] flags,
	output logic [pfpu_pkg::data_w-1:0] a,
	output logic [pfpu_pkg::data_w-1:0] b,
	input  logic [pfpu_pkg::data_w-1:0] r,
	input  logic w_en,
	input  logic [pfpu_pkg::reg_aw-1:0] a_addr,
	input  logic [pfpu_pkg::reg_aw-1:0] b_addr,
	input  logic [pfpu_pkg::reg_aw-1:0] w_addr,
	input  logic c_en,
	input  logic [pfpu_pkg::reg_aw-1:0] c_addr,
	input  logic c_w_en,
	input  logic [pfpu_pkg::data_w-1:0] c_di,
	output logic [pfpu_pkg::data_w-1:0] c_do,
	input  logic [pfpu_pkg::data_w-1:0] r0,
	input  logic [pfpu_pkg::data_w-1:0] r1,
	output logic err_stray
);
	import pfpu_pkg::*;

	logic [reg_aw-1:0] p1_a, p2_a, p3_a;
	logic [data_w-1:0] p1_d, p2_d, p3_d;
	logic p3_en;
	logic [1:0] rflags;
	logic p1_ovl_en, p2_ovl_en;
	logic [data_w-1:0] p1_ovl, p2_ovl;

	// value an overlay address reads instead of the RAM.
	function automatic logic [data_w-1:0] overlay_val(input logic [reg_aw-1:0] addr,
			input logic [data_w-1:0] v0, input logic [data_w-1:0] v1,
			input logic [1:0] fl);
		case (addr)
			reg_r0: return v0;
			reg_r1: return v1;
			default: return {{(data_w-2){1'b0}}, fl}; // the flags register reads 2 bits.
		endcase
	endfunction

	pfpu_tpram i_tpram (
		.sys_clk(sys_clk),
		.p1_a(p1_a),
		.p2_a(p2_a),
		.p1_d(p1_d),
		.p2_d(p2_d),
		.p3_en(p3_en),
		.p3_a(p3_a),
		.p3_d(p3_d)
	);

	assign p1_a = c_en ? c_addr : a_addr; // the host wins port 1.
	assign p2_a = b_addr; // port 2 only ever serves operand b.
	assign p3_en = c_en ? c_w_en : w_en;
	assign p3_a = c_en ? c_addr : w_addr;
	assign p3_d = c_en ? c_di : r;

	// overlay decode is registered to line up with the RAM read.
	always_ff @(posedge sys_clk) begin
		p1_ovl_en <= (p1_a <= reg_flags);
		p2_ovl_en <= (p2_a <= reg_flags);
		p1_ovl <= overlay_val(p1_a, r0, r1, rflags);
		p2_ovl <= overlay_val(p2_a, r0, r1, rflags);
	end

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			rflags <= '0;
			flags <= '0;
		end else begin
			if (p3_en && p3_a == reg_flags) begin
				rflags <= p3_d[1:0]; // only the low two bits are kept.
			end
			flags <= rflags; // delayed so the ALU sees flags with its operands.
		end
	end

	assign a = p1_ovl_en ? p1_ovl : p1_d;
	assign b = p2_ovl_en ? p2_ovl : p2_d;
	assign c_do = a; // host reads share the operand a path.
	assign err_stray = p3_en & (p3_a == reg_r0); // R0 is read-only, so flag the attempt.
endmodule

// File: hdl/pfpu_tpram.sv
// ----------------------------------------------------------------------
// register storage.
// 128 words, two registered read ports and one write port.
// ----------------------------------------------------------------------
module pfpu_tpram (
	input  logic sys_clk,
	input  logic [pfpu_pkg::reg_aw-1:0] p1_a,
	input  logic [pfpu_pkg::reg_aw-1:0] p2_a,
	output logic [pfpu_pkg::data_w-1:0] p1_d,
	output logic [pfpu_pkg::data_w-1:0] p2_d,
	input  logic p3_en,
	input  logic [pfpu_pkg::reg_aw-1:0] p3_a,
	input  logic [pfpu_pkg::data_w-1:0] p3_d
);
	import pfpu_pkg::*;

	logic [data_w-1:0] mem [2**reg_aw];

	always_ff @(posedge sys_clk) begin
		if (p3_en) begin
			mem[p3_a] <= p3_d; // visible to reads from the next edge on.
		end
		p1_d <= mem[p1_a]; // a read colliding with the write sees the old word.
		p2_d <= mem[p2_a];
	end
endmodule

// File: hdl/pfpu_csr_pkg.sv
// ----------------------------------------------------------------------
// vertex unit host map.
// AXI4-Lite addresses, control and status bit positions.
// ----------------------------------------------------------------------
package pfpu_csr_pkg;
	localparam int axil_aw = 12; // 4 KB of address space.

	localparam logic [axil_aw-1:0] addr_ctrl = 12'h000; // start and error clear.
	localparam logic [axil_aw-1:0] addr_status = 12'h004; // busy, done and stray bits.
	localparam logic [axil_aw-1:0] addr_r0 = 12'h008; // value seen at register 0.
	localparam logic [axil_aw-1:0] addr_r1 = 12'h00C; // value seen at register 1.
	localparam logic [axil_aw-1:0] addr_len = 12'h010; // number of instructions to run.
	localparam logic [axil_aw-1:0] reg_base = 12'h200; // register n at base plus 4 n.
	localparam logic [axil_aw-1:0] code_base = 12'h400; // same layout for code words.
	localparam int win_lsb = 9; // each window spans 512 bytes.

	localparam int ctrl_start = 0;
	localparam int ctrl_clr = 1;

	localparam int st_busy = 0;
	localparam int st_done = 1;
	localparam int st_stray = 2;

	localparam logic [1:0] resp_okay = 2'b00; // the only response this slave gives.
endpackage

// File: hdl/pfpu_pkg.sv
// ----------------------------------------------------------------------
// vertex unit core definitions.
// register and code sizes, instruction layout, opcodes and the
// sequencer states.
// ----------------------------------------------------------------------
package pfpu_pkg;
	localparam int data_w = 32; // all operations are 32-bit integer.
	localparam int reg_aw = 7; // 128 registers.
	localparam int code_aw = 7; // 128 instruction words.

	localparam logic [reg_aw-1:0] reg_r0 = reg_aw'(0); // reads the first host input.
	localparam logic [reg_aw-1:0] reg_r1 = reg_aw'(1); // reads the second host input.
	localparam logic [reg_aw-1:0] reg_flags = reg_aw'(2); // two flag bits live here.

	// instruction word fields, given as low bit positions.
	localparam int insn_op_lo = 28; // opcode in bits 31 to 28.
	localparam int insn_op_w = 4;
	localparam int insn_dest_lo = 14; // destination in bits 20 to 14.
	localparam int insn_a_lo = 7; // operand a address in bits 13 to 7.
	localparam int insn_b_lo = 0; // operand b address in bits 6 to 0.

	typedef enum logic [3:0] {
		op_nop = 4'h0, // writes nothing back.
		op_add = 4'h1,
		op_sub = 4'h2,
		op_mul = 4'h3, // low half of the product.
		op_and = 4'h4,
		op_or = 4'h5,
		op_xor = 4'h6,
		op_shl = 4'h7, // shift a by b[4:0].
		op_shr = 4'h8,
		op_sel = 4'h9 // a when flag 0 is set, else b.
	} pfpu_op_e;

	typedef enum logic [1:0] {seq_idle, seq_run, seq_drain} seq_state_e;
endpackage
